// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - src/fetch_pkg.sv
  - src/fetch_line_if.sv
  - src/instr_align.sv
  - src/pc_sequencer.sv
  - src/l0_line_buffer.sv
  - src/fetch_unit.sv
  - src/fetch_top.sv
  - target: test
    files:
      - testbench/fetch_props.sv
      - testbench/fetch_checker.sv
      - testbench/fetch_tb.sv

// ==== flist.f ====
src/fetch_pkg.sv
src/fetch_line_if.sv
src/instr_align.sv
src/pc_sequencer.sv
src/l0_line_buffer.sv
src/fetch_unit.sv
src/fetch_top.sv
testbench/fetch_props.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

// ==== src/fetch_line_if.sv ====
// line transfer, L0 buffer to fetch unit

interface fetch_line_if;
  logic                          valid;    // line presented
  logic                          ready;    // fetch can take it
  logic [fetch_pkg::LINE_W-1:0]  line;     // full cacheline
  logic [fetch_pkg::ADDR_W-1:0]  pc;       // fetch pc inside that line
  logic                          from_l1i; // line came from a miss fill

  modport src (output valid, line, pc, from_l1i, input ready);
  modport dst (input valid, line, pc, from_l1i, output ready);
endinterface

// ==== src/fetch_pkg.sv ====
// fetch front end shared definitions

package fetch_pkg;

  localparam int INSTR_W     = 32;             // one instruction word
  localparam int INSTR_BYTES = INSTR_W / 8;    // 4 bytes per slot
  localparam int FETCH_WIDTH = 4;              // slots per bundle
  localparam int LINE_BYTES  = 64;             // cacheline size
  localparam int LINE_W      = LINE_BYTES * 8; // 512 bit line
  localparam int OFFSET_W    = $clog2(LINE_BYTES);
  localparam int ADDR_W      = 64;
  localparam int TAG_W       = ADDR_W - OFFSET_W; // line address bits

  // consumed_bytes must hold FETCH_WIDTH * INSTR_BYTES
  localparam int CNT_W = $clog2(FETCH_WIDTH * INSTR_BYTES + 1);

  // padding for slots past the end of the line
  localparam logic [INSTR_W-1:0] NOP_INSTR = 32'hD503201F;

  // bundle handed to decode
  typedef struct packed {
    logic [FETCH_WIDTH-1:0][INSTR_W-1:0] instrs; // slot 0 in the low word
    logic [FETCH_WIDTH-1:0]              mask;   // slot valid bits
    logic [ADDR_W-1:0]                   pc;     // pc of slot 0
  } fetch_bundle_t;

endpackage

// ==== src/fetch_top.sv ====
// instruction fetch front end top

module fetch_top (
  input  logic                                                    clk_in,
  input  logic                                                    rst_N_in,
  input  logic                                                    redirect_valid,
  input  logic [fetch_pkg::ADDR_W-1:0]                            redirect_pc,
  output logic                                                    l1i_req_valid,
  output logic [fetch_pkg::ADDR_W-1:0]                            l1i_req_addr,
  input  logic                                                    l1i_resp_valid,
  input  logic [fetch_pkg::LINE_W-1:0]                            l1i_resp_line,
  output logic                                                    fetch_valid,
  output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_W-1:0] fetch_instrs,
  output logic [fetch_pkg::FETCH_WIDTH-1:0]                       fetch_mask,
  output logic [fetch_pkg::ADDR_W-1:0]                            fetch_pc,
  input  logic                                                    decode_ready
);

  logic [fetch_pkg::ADDR_W-1:0] seq_pc;     // sequencer pc, not the bundle pc
  logic                         pc_valid;
  logic                         pc_taken;
  logic                         advance;
  logic [fetch_pkg::CNT_W-1:0]  consumed_bytes;
  fetch_pkg::fetch_bundle_t     bundle;

  fetch_line_if line_if ();

  pc_sequencer i_pc_seq (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .advance        (advance),
    .consumed_bytes (consumed_bytes),
    .pc_taken       (pc_taken),
    .fetch_pc       (seq_pc),
    .pc_valid       (pc_valid)
  );

  l0_line_buffer i_l0 (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .redirect_valid (redirect_valid),
    .fetch_pc       (seq_pc),
    .pc_valid       (pc_valid),
    .pc_taken       (pc_taken),
    .l1i_req_valid  (l1i_req_valid),
    .l1i_req_addr   (l1i_req_addr),
    .l1i_resp_valid (l1i_resp_valid),
    .l1i_resp_line  (l1i_resp_line),
    .line_out       (line_if.src)
  );

  fetch_unit i_fetch (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .redirect_valid (redirect_valid),
    .line_in        (line_if.dst),
    .decode_ready   (decode_ready),
    .bundle         (bundle),
    .fetch_valid    (fetch_valid),
    .advance        (advance),
    .consumed_bytes (consumed_bytes)
  );

  // decode port fields
  assign fetch_instrs = bundle.instrs;
  assign fetch_mask   = bundle.mask;
  assign fetch_pc     = bundle.pc;

endmodule

// ==== src/fetch_unit.sv ====
// fetch unit, aligns the line and feeds decode

module fetch_unit (
  input  logic                          clk_in,
  input  logic                          rst_N_in,
  input  logic                          redirect_valid,
  fetch_line_if.dst                     line_in,
  input  logic                          decode_ready,
  output fetch_pkg::fetch_bundle_t      bundle,
  output logic                          fetch_valid,
  output logic                          advance,
  output logic [fetch_pkg::CNT_W-1:0]   consumed_bytes
);

  logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_W-1:0] al_instrs;
  logic [fetch_pkg::FETCH_WIDTH-1:0]                         al_mask;

  fetch_pkg::fetch_bundle_t bundle_q;
  logic                     valid_q;
  logic                     xfer;

  instr_align i_align (
    .offset (line_in.pc[fetch_pkg::OFFSET_W-1:0]),
    .line   (line_in.line),
    .instrs (al_instrs),
    .mask   (al_mask)
  );

  // take a line when the bundle slot is free or drains this cycle
  assign line_in.ready = (~valid_q | decode_ready) & ~redirect_valid;
  assign xfer          = line_in.valid & line_in.ready;

  // bytes used = 4 per valid slot
  always_comb begin
    consumed_bytes = '0;
    for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
      if (al_mask[i]) begin
        consumed_bytes = consumed_bytes + fetch_pkg::CNT_W'(fetch_pkg::INSTR_BYTES);
      end
    end
  end

  assign advance = xfer; // one pulse per accepted line

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      valid_q <= 1'b0;
    end else if (redirect_valid) begin
      valid_q <= 1'b0; // drop held bundle on redirect
    end else if (xfer) begin
      valid_q <= 1'b1;
    end else if (decode_ready) begin
      valid_q <= 1'b0; // drained, nothing new
    end
  end

  // bundle payload, held while decode stalls
  always_ff @(posedge clk_in) begin
    if (xfer) begin
      bundle_q.instrs <= al_instrs;
      bundle_q.mask   <= al_mask;
      bundle_q.pc     <= line_in.pc;
    end
  end

  assign bundle      = bundle_q;
  assign fetch_valid = valid_q;

endmodule

// ==== src/instr_align.sv ====
// slot extraction from a cacheline

module instr_align (
  input  logic [fetch_pkg::OFFSET_W-1:0]                          offset,
  input  logic [fetch_pkg::LINE_W-1:0]                            line,
  output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_W-1:0] instrs,
  output logic [fetch_pkg::FETCH_WIDTH-1:0]                       mask
);

  for (genvar i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin : g_slot
    logic [fetch_pkg::OFFSET_W:0] pos; // byte position, one spare bit for overrun

    assign pos = {1'b0, offset} + (fetch_pkg::OFFSET_W + 1)'(i * fetch_pkg::INSTR_BYTES);

    // whole word must fit inside the line
    assign mask[i] = (pos + fetch_pkg::INSTR_BYTES) <= fetch_pkg::LINE_BYTES;

    // little endian: byte b sits at line[b*8 +: 8]
    assign instrs[i] = mask[i] ? line[pos*8 +: fetch_pkg::INSTR_W]
                               : fetch_pkg::NOP_INSTR;
  end

endmodule

// ==== src/l0_line_buffer.sv ====
// two entry L0 line buffer with L1i miss path

module l0_line_buffer (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  logic                         redirect_valid,
  input  logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
  input  logic                         pc_valid,
  output logic                         pc_taken,
  output logic                         l1i_req_valid,
  output logic [fetch_pkg::ADDR_W-1:0] l1i_req_addr,
  input  logic                         l1i_resp_valid,
  input  logic [fetch_pkg::LINE_W-1:0] l1i_resp_line,
  fetch_line_if.src                    line_out
);

  typedef enum logic [1:0] {
    st_idle,    // ready for a new pc
    st_req,     // request pulse to L1i
    st_wait,    // waiting on the response
    st_present  // line offered to fetch
  } state_t;

  state_t state_q;

  logic [1:0]                        ent_valid_q;
  logic [fetch_pkg::TAG_W-1:0]       ent_tag_q  [2];
  logic [fetch_pkg::LINE_W-1:0]      ent_line_q [2];
  logic                              victim_q;  // round robin fill pointer
  logic                              sel_q;     // entry being presented
  logic                              discard_q; // stale response pending
  logic                              from_l1i_q;
  logic [fetch_pkg::ADDR_W-1:0]      req_pc_q;  // pc that owns the current line

  logic [1:0] hit_vec;
  logic       hit;

  // tag compare against the offered pc
  for (genvar i = 0; i < 2; i++) begin : g_lookup
    assign hit_vec[i] = ent_valid_q[i] &
                        (ent_tag_q[i] == fetch_pc[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W]);
  end
  assign hit = |hit_vec;

  // no new pc while busy or while the back end redirects
  assign pc_taken = pc_valid & (state_q == st_idle) & ~redirect_valid;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state_q     <= st_idle;
      ent_valid_q <= '0;
      victim_q    <= 1'b0;
      sel_q       <= 1'b0;
      discard_q   <= 1'b0;
      from_l1i_q  <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (pc_taken) begin
            state_q    <= hit ? st_present : st_req;
            sel_q      <= hit_vec[1]; // only meaningful on a hit
            from_l1i_q <= 1'b0;
          end
        end
        st_req: begin
          state_q   <= st_wait;
          discard_q <= redirect_valid; // request already out, must swallow it
        end
        st_wait: begin
          if (l1i_resp_valid) begin
            // fill even when stale, the data is right for that address
            ent_valid_q[victim_q] <= 1'b1;
            victim_q              <= ~victim_q;
            sel_q                 <= victim_q;
            from_l1i_q            <= 1'b1;
            discard_q             <= 1'b0;
            state_q <= (discard_q | redirect_valid) ? st_idle : st_present;
          end else if (redirect_valid) begin
            discard_q <= 1'b1;
          end
        end
        st_present: begin
          if (redirect_valid || line_out.ready) state_q <= st_idle; // taken or dropped
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // payload side, no reset
  always_ff @(posedge clk_in) begin
    if (pc_taken) req_pc_q <= fetch_pc;
    if (state_q == st_wait && l1i_resp_valid) begin
      ent_tag_q[victim_q]  <= req_pc_q[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W];
      ent_line_q[victim_q] <= l1i_resp_line;
    end
  end

  assign l1i_req_valid = (state_q == st_req); // single cycle pulse
  assign l1i_req_addr  = {req_pc_q[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W],
                          {fetch_pkg::OFFSET_W{1'b0}}}; // line aligned

  assign line_out.valid    = (state_q == st_present);
  assign line_out.line     = ent_line_q[sel_q];
  assign line_out.pc       = req_pc_q;
  assign line_out.from_l1i = from_l1i_q;

endmodule

// ==== src/pc_sequencer.sv ====
// fetch pc sequencer

module pc_sequencer (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  logic                         redirect_valid,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
  input  logic                         advance,        // fetch accepted a line
  input  logic [fetch_pkg::CNT_W-1:0]  consumed_bytes, // bytes used from that line
  input  logic                         pc_taken,       // buffer latched fetch_pc
  output logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
  output logic                         pc_valid
);

  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic                         started_q;   // first cycle out of reset done
  logic                         in_flight_q; // pc handed out, line not yet accepted

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pc_q        <= '0;
      started_q   <= 1'b0;
      in_flight_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (redirect_valid) begin // back end wins over fall-through
        pc_q        <= redirect_pc;
        in_flight_q <= 1'b0;
      end else if (advance) begin
        pc_q        <= pc_q + fetch_pkg::ADDR_W'(consumed_bytes); // fall-through
        in_flight_q <= 1'b0;
      end else if (pc_taken) begin
        in_flight_q <= 1'b1; // wait for the line to be accepted
      end
    end
  end

  assign fetch_pc = pc_q;
  assign pc_valid = started_q & ~in_flight_q; // one pc offered per line

endmodule

// ==== testbench/fetch_checker.sv ====
// decode port checker

module fetch_checker (
  input  logic                                                      clk_in,
  input  logic                                                      rst_N_in,
  input  logic                                                      redirect_valid,
  input  logic [fetch_pkg::ADDR_W-1:0]                              redirect_pc,
  input  logic                                                      fetch_valid,
  input  logic                                                      decode_ready,
  input  logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_W-1:0] fetch_instrs,
  input  logic [fetch_pkg::FETCH_WIDTH-1:0]                         fetch_mask,
  input  logic [fetch_pkg::ADDR_W-1:0]                              fetch_pc,
  input  logic                                                      l1i_req_valid,
  input  logic                                                      no_req,  // L0 hits only
  input  logic [127:0]                                              test_name,
  output int                                                        checks,
  output int                                                        errors,
  output int                                                        bundles
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [fetch_pkg::ADDR_W-1:0] exp_pc; // pc of the next bundle decode should see
  int                           rst_edges;

  initial begin
    checks    = 0;
    errors    = 0;
    bundles   = 0;
    rst_edges = 0;
    exp_pc    = '0;
  end

  task automatic compare_field(input string what, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("Error %0s %0s: expected %h, actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  // expected bundle straight from the alignment rule
  task automatic check_bundle();
    logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_W-1:0] e_instrs;
    logic [fetch_pkg::FETCH_WIDTH-1:0]                         e_mask;
    int                                                        off;
    int                                                        used;
    used = 0;
    for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
      off = int'(exp_pc[fetch_pkg::OFFSET_W-1:0]) + 4 * i; // 4 byte words
      e_mask[i] = (off + 4 <= fetch_pkg::LINE_BYTES);
      if (e_mask[i]) begin
        e_instrs[i] = fetch_pkg::INSTR_W'(exp_pc + 64'(4 * i)); // word holds its address
        used += 4;
      end else begin
        e_instrs[i] = fetch_pkg::NOP_INSTR;
      end
    end
    compare_field("pc", 128'(exp_pc), 128'(fetch_pc));
    compare_field("mask", 128'(e_mask), 128'(fetch_mask));
    compare_field("instrs", 128'(e_instrs), 128'(fetch_instrs));
    exp_pc = exp_pc + 64'(used);
    bundles++;
  endtask

  // negedge: handshake values settled for the coming edge
  always @(negedge clk_in) begin
    if (rst_N_in) begin
      if (rst_edges > 0) begin
        compare_field("fetch_valid", 128'(1'b0), 128'(fetch_valid));
        compare_field("l1i_req_valid", 128'(1'b0), 128'(l1i_req_valid));
      end
      rst_edges++;
    end else begin
      if (redirect_valid) exp_pc = redirect_pc; // restart point
      else if (fetch_valid && decode_ready) check_bundle();
      if (no_req) begin
        compare_field("l1i_req_valid", 128'(1'b0), 128'(l1i_req_valid)); // line must hit in L0
      end
    end
  end

endmodule

// ==== testbench/fetch_props.sv ====
// fetch unit handshake properties

module fetch_props (
  input logic                         clk_in,
  input logic                         rst_N_in,
  input logic                         redirect_valid,
  input logic                         decode_ready,
  input logic                         fetch_valid,
  input logic                         advance,
  input logic                         line_valid,
  input logic                         line_ready,
  input logic [fetch_pkg::ADDR_W-1:0] line_pc,
  input logic                         line_from_l1i,
  input fetch_pkg::fetch_bundle_t     bundle
);
  timeunit 1ns;
  timeprecision 1ps;

  // stalled bundle must not move
  a_stall_hold: assert property (@(posedge clk_in) disable iff (rst_N_in)
    fetch_valid && !decode_ready |=> $stable(bundle))
    else $error("bundle changed while decode was stalled");

  a_redirect_flush: assert property (@(posedge clk_in) disable iff (rst_N_in)
    redirect_valid |=> !fetch_valid) // held bundle dropped
    else $error("fetch_valid still high after a redirect");

  // accepted line lands in the bundle register
  a_advance_xfer: assert property (@(posedge clk_in) disable iff (rst_N_in)
    advance |=> fetch_valid && (bundle.pc == $past(line_pc)))
    else $error("advance without the line landing in the bundle register");

  // offered line holds still until taken, hit or fill alike
  a_line_hold: assert property (@(posedge clk_in) disable iff (rst_N_in)
    line_valid && !line_ready && !redirect_valid |=>
      line_valid && $stable(line_pc) && $stable(line_from_l1i))
    else $error("presented line changed before the transfer");

endmodule

bind fetch_unit fetch_props i_props (
  .clk_in         (clk_in),
  .rst_N_in       (rst_N_in),
  .redirect_valid (redirect_valid),
  .decode_ready   (decode_ready),
  .fetch_valid    (fetch_valid),
  .advance        (advance),
  .line_valid     (line_in.valid),
  .line_ready     (line_in.ready),
  .line_pc        (line_in.pc),
  .line_from_l1i  (line_in.from_l1i),
  .bundle         (bundle)
);

// ==== testbench/fetch_tb.sv ====
// fetch front end testbench

module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 6;

  logic                                                      clk_in;
  logic                                                      rst_N_in;
  logic                                                      redirect_valid;
  logic [fetch_pkg::ADDR_W-1:0]                              redirect_pc;
  logic                                                      l1i_req_valid;
  logic [fetch_pkg::ADDR_W-1:0]                              l1i_req_addr;
  logic                                                      l1i_resp_valid;
  logic [fetch_pkg::LINE_W-1:0]                              l1i_resp_line;
  logic                                                      fetch_valid;
  logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::INSTR_W-1:0] fetch_instrs;
  logic [fetch_pkg::FETCH_WIDTH-1:0]                         fetch_mask;
  logic [fetch_pkg::ADDR_W-1:0]                              fetch_pc;
  logic                                                      decode_ready;

  // stimulus table: name, start pc, bundles, stalls, L0 hits only
  logic [127:0]                 row_name  [NUM_ROWS];
  logic [fetch_pkg::ADDR_W-1:0] row_pc    [NUM_ROWS];
  int                           row_cnt   [NUM_ROWS];
  logic                         row_stall [NUM_ROWS];
  logic                         row_nreq  [NUM_ROWS];

  logic [127:0]                 cur_name;
  logic                         no_req;
  integer                       seed;
  int                           accepted;
  int                           cycle_cnt;
  int                           limit;
  int                           checks, errors, bundles;
  logic                         busy;      // L1i model has a request
  int                           lat_cnt;
  logic [fetch_pkg::ADDR_W-1:0] resp_addr;

  fetch_top i_dut (.*);

  fetch_checker i_chk (
    .clk_in (clk_in), .rst_N_in (rst_N_in), .redirect_valid (redirect_valid),
    .redirect_pc (redirect_pc), .fetch_valid (fetch_valid), .decode_ready (decode_ready),
    .fetch_instrs (fetch_instrs), .fetch_mask (fetch_mask), .fetch_pc (fetch_pc),
    .l1i_req_valid (l1i_req_valid), .no_req (no_req), .test_name (cur_name),
    .checks (checks), .errors (errors), .bundles (bundles)
  );

  task automatic set_row(input int idx, input logic [127:0] name, input logic [63:0] pc,
                         input int cnt, input logic stall, input logic nreq);
    row_name[idx]  = name;
    row_pc[idx]    = pc;
    row_cnt[idx]   = cnt;
    row_stall[idx] = stall;
    row_nreq[idx]  = nreq;
  endtask

  // every word equals its own byte address
  function automatic logic [fetch_pkg::LINE_W-1:0] build_line(input logic [63:0] base);
    logic [fetch_pkg::LINE_W-1:0] l;
    for (int k = 0; k < fetch_pkg::LINE_BYTES / 4; k++) l[k*32 +: 32] = 32'(base + 64'(k * 4));
    return l;
  endfunction

  initial clk_in = 1'b0;
  always #10 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit > 0 && cycle_cnt >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failures found");
      $finish;
    end
  end

  // L1i model, one request at a time, 1 to 4 cycles
  always @(posedge clk_in) begin
    l1i_resp_valid <= 1'b0;
    if (rst_N_in) begin
      busy = 1'b0;
    end else if (l1i_req_valid) begin
      busy      = 1'b1;
      resp_addr = l1i_req_addr;
      lat_cnt   = 1 + ($unsigned($random(seed)) % 4);
    end else if (busy) begin
      lat_cnt = lat_cnt - 1;
      if (lat_cnt == 0) begin
        busy = 1'b0;
        l1i_resp_valid <= 1'b1;
        l1i_resp_line  <= build_line(resp_addr);
      end
    end
  end

  initial begin
    seed = 82;
    rst_N_in = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    l1i_resp_valid = 1'b0;
    l1i_resp_line = '0;
    decode_ready = 1'b0;
    no_req = 1'b0;
    cur_name = "reset";
    cycle_cnt = 0;
    set_row(0, "aligned", 64'h1000, 8, 1'b0, 1'b0);
    set_row(1, "line_end", 64'h2038, 3, 1'b0, 1'b0);
    set_row(2, "l0_reuse", 64'h2038, 3, 1'b0, 1'b1);
    set_row(3, "stale_miss", 64'h8000, 0, 1'b0, 1'b0);
    set_row(4, "after_redirect", 64'h9010, 6, 1'b0, 1'b0);
    set_row(5, "stalls", 64'h4004, 12, 1'b1, 1'b0);
    limit = 100;
    for (int r = 0; r < NUM_ROWS; r++) limit += row_cnt[r] * 12;
    repeat (10) @(posedge clk_in);
    rst_N_in <= 1'b0;
    repeat (3) @(posedge clk_in);
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name       <= row_name[r];
      no_req         <= row_nreq[r];
      redirect_valid <= 1'b1;
      redirect_pc    <= row_pc[r];
      decode_ready   <= 1'b0;
      @(posedge clk_in);
      redirect_valid <= 1'b0;
      accepted = 0;
      if (row_cnt[r] == 0) repeat (2) @(posedge clk_in); // leave the miss in flight
      while (accepted < row_cnt[r]) begin
        decode_ready <= row_stall[r] ? (($random(seed) & 3) != 0) : 1'b1;
        @(negedge clk_in);
        if (fetch_valid && decode_ready) accepted++;
        @(posedge clk_in);
      end
    end
    decode_ready <= 1'b0;
    repeat (5) @(posedge clk_in);
    $display("bundles: %0d, checks: %0d, errors: %0d", bundles, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
